// ==== verilog/ecc_consts.svh ====
`ifndef ECC_CONSTS_SVH
`define ECC_CONSTS_SVH

// protected word geometry
`define ECC_DATA_W 84
`define ECC_PARITY_W 8

// low part of each syndrome column, holds the hamming position
`define ECC_POS_W 7

// input buffer depth, also the credits the upstream starts with
`define ECC_IN_DEPTH 4

// slots in the downstream buffer
`define ECC_OUT_CREDITS 4

`endif

// ==== verilog/ecc_pkg.sv ====
`include "ecc_consts.svh"

package ecc_pkg;

    typedef logic [`ECC_DATA_W-1:0] ecc_data_t;
    typedef logic [`ECC_PARITY_W-1:0] ecc_parity_t;
    typedef logic [2:0] ecc_credit_t;

    typedef struct packed {
        ecc_data_t data;
        ecc_parity_t parity;
        logic bypass;
    } ecc_word_t;

    typedef struct packed {
        ecc_data_t data;
        ecc_parity_t calc_parity;               // check bits of the received data
        ecc_parity_t syndrome;
        logic bypass;
    } ecc_syn_t;

    typedef struct packed {
        ecc_data_t data;                        // corrected unless bypassed
        ecc_parity_t calc_parity;
        logic sbit_err;
        logic dbit_err;
    } ecc_result_t;

    // syndrome column of data bit idx
    // positions run from 3 upward and skip the powers of two,
    // the top bit makes the column weight odd
    function automatic ecc_parity_t ecc_column(input int idx);
        logic [`ECC_POS_W-1:0] pos;
        int cnt;
        pos = '0;
        cnt = 0;
        for (int p = 3; p < (1 << `ECC_POS_W); p++) begin
            if ((p & (p - 1)) != 0) begin   // not a power of two
                if (cnt == idx) begin
                    pos = `ECC_POS_W'(p);
                end
                cnt++;
            end
        end
        return {~(^pos), pos};
    endfunction

    // check bit j covers every data bit whose column has bit j set
    function automatic ecc_parity_t ecc_encode(input ecc_data_t d);
        ecc_parity_t p;
        ecc_parity_t col;
        p = '0;
        for (int i = 0; i < `ECC_DATA_W; i++) begin
            col = ecc_column(i);
            for (int j = 0; j < `ECC_PARITY_W; j++) begin
                if (col[j]) begin
                    p[j] = p[j] ^ d[i];
                end
            end
        end
        return p;
    endfunction

endpackage

// ==== verilog/ecc_issue.sv ====
`timescale 1ns/10ps
`include "ecc_consts.svh"

module ecc_issue
    import ecc_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic in_valid,
    input  ecc_word_t in_word,
    input  logic out_credit,
    output logic in_credit,
    output logic issue_valid,
    output ecc_word_t issue_word
);

    localparam int ptr_w = $clog2(`ECC_IN_DEPTH);
    localparam int cnt_w = $clog2(`ECC_IN_DEPTH + 1);

    ecc_word_t mem [`ECC_IN_DEPTH];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;
    ecc_credit_t credits;
    logic pop;

    // pop only with a downstream slot reserved
    assign pop = (count != '0) && (credits != '0);

    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
        if (ptr == ptr_w'(`ECC_IN_DEPTH - 1)) begin
            return '0;
        end
        return ptr + ptr_w'(1);
    endfunction

    always_ff @(posedge clk) begin
        if (in_valid) begin
            mem[wr_ptr] <= in_word;     // upstream credits guarantee a free slot
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (in_valid) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count <= count + cnt_w'(in_valid) - cnt_w'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            credits <= ecc_credit_t'(`ECC_OUT_CREDITS);
            issue_valid <= 1'b0;
            in_credit <= 1'b0;
        end else begin
            credits <= credits + ecc_credit_t'(out_credit) - ecc_credit_t'(pop);
            issue_valid <= pop;
            in_credit <= pop;           // freed buffer slot goes back upstream
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            issue_word <= mem[rd_ptr];
        end
    end

endmodule

// ==== verilog/ecc_syndrome_stage.sv ====
`timescale 1ns/10ps

module ecc_syndrome_stage
    import ecc_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic issue_valid,
    input  ecc_word_t issue_word,
    output logic syn_valid,
    output ecc_syn_t syn
);

    ecc_parity_t calc_parity;
    ecc_syn_t syn_d;

    // recompute check bits from the received data
    assign calc_parity = ecc_encode(issue_word.data);

    always_comb begin
        syn_d.data = issue_word.data;
        syn_d.calc_parity = calc_parity;
        syn_d.syndrome = calc_parity ^ issue_word.parity;
        syn_d.bypass = issue_word.bypass;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            syn_valid <= 1'b0;
        end else begin
            syn_valid <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            syn <= syn_d;
        end
    end

endmodule

// ==== verilog/ecc_correct_stage.sv ====
`timescale 1ns/10ps
`include "ecc_consts.svh"

module ecc_correct_stage
    import ecc_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic syn_valid,
    input  ecc_syn_t syn,
    output logic out_valid,
    output ecc_result_t out_word
);

    ecc_data_t mask;
    logic data_hit;
    logic check_hit;
    logic zero_syn;
    ecc_result_t result;

    // match the syndrome against every data column
    always_comb begin
        mask = '0;
        data_hit = 1'b0;
        for (int i = 0; i < `ECC_DATA_W; i++) begin
            if (syn.syndrome == ecc_column(i)) begin
                mask[i] = 1'b1;
                data_hit = 1'b1;
            end
        end
    end

    assign zero_syn = (syn.syndrome == '0);
    // single bit set means the error sits in a check bit
    assign check_hit = !zero_syn && ((syn.syndrome & (syn.syndrome - ecc_parity_t'(1))) == '0);

    always_comb begin
        result.calc_parity = syn.calc_parity;
        if (syn.bypass) begin
            result.data = syn.data;
            result.sbit_err = 1'b0;
            result.dbit_err = 1'b0;
        end else begin
            result.data = syn.data ^ mask;  // mask is zero unless a data column matched
            result.sbit_err = data_hit || check_hit;
            result.dbit_err = !zero_syn && !data_hit && !check_hit;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= syn_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (syn_valid) begin
            out_word <= result;
        end
    end

endmodule

// ==== verilog/ecc_pipe_top.sv ====
`timescale 1ns/10ps

module ecc_pipe_top
    import ecc_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic in_valid,
    input  ecc_word_t in_word,
    input  logic out_credit,
    output logic in_credit,
    output logic out_valid,
    output ecc_result_t out_word
);

    logic issue_valid;
    ecc_word_t issue_word;
    logic syn_valid;
    ecc_syn_t syn;

    // buffer and credit handling
    ecc_issue ecc_issue_i (
        .clk(clk),
        .reset(reset),
        .in_valid(in_valid),
        .in_word(in_word),
        .out_credit(out_credit),
        .in_credit(in_credit),
        .issue_valid(issue_valid),
        .issue_word(issue_word)
    );

    ecc_syndrome_stage ecc_syndrome_stage_i (
        .clk(clk),
        .reset(reset),
        .issue_valid(issue_valid),
        .issue_word(issue_word),
        .syn_valid(syn_valid),
        .syn(syn)
    );

    ecc_correct_stage ecc_correct_stage_i (
        .clk(clk),
        .reset(reset),
        .syn_valid(syn_valid),
        .syn(syn),
        .out_valid(out_valid),
        .out_word(out_word)
    );

endmodule

// ==== dv/ecc_pipe_tb.sv ====
`timescale 1ns/10ps
`include "ecc_consts.svh"

module ecc_pipe_tb
    import ecc_pkg::*;
();

    localparam int clk_period = 20;
    localparam int n_vecs = 30;
    localparam int n_bp = 8;                    // words sent while credits are held back
    localparam int n_main = n_vecs - n_bp;
    localparam int watchdog_ns = (n_vecs + 20) * 4 * clk_period;

    localparam logic [2:0] k_clean = 3'd0;
    localparam logic [2:0] k_sdata = 3'd1;
    localparam logic [2:0] k_scheck = 3'd2;
    localparam logic [2:0] k_double = 3'd3;
    localparam logic [2:0] k_bypass = 3'd4;
    localparam logic [2:0] k_credit = 3'd5;

    typedef struct packed {
        logic [2:0] kind;
        ecc_data_t data;                        // clean data
        ecc_data_t dflip;
        ecc_parity_t pflip;
        logic bypass;
        logic exp_sbit;
        logic exp_dbit;
    } vec_t;

    logic clk;
    logic reset;
    logic in_valid;
    ecc_word_t in_word;
    logic out_credit;
    logic in_credit;
    logic out_valid;
    ecc_result_t out_word;

    vec_t vecs [n_vecs];
    int fill_idx;
    ecc_parity_t cols [`ECC_DATA_W];
    int exp_q [$];
    int sent;
    int returned;
    int owed;                                   // downstream slots not yet freed
    int recv_count;
    int test_count;
    int fail_count;
    int error_count;
    logic hold;

    ecc_pipe_top ecc_pipe_top_i (
        .clk(clk),
        .reset(reset),
        .in_valid(in_valid),
        .in_word(in_word),
        .out_credit(out_credit),
        .in_credit(in_credit),
        .out_valid(out_valid),
        .out_word(out_word)
    );

    initial clk = 1'b0;
    always #(clk_period / 2) clk = ~clk;

    // hamming positions skip powers of two, top bit forces odd column weight
    task automatic build_columns();
        logic [`ECC_POS_W-1:0] pos;
        int n;
        n = 0;
        for (int p = 3; n < `ECC_DATA_W; p++) begin
            if ($countones(p) > 1) begin
                pos = p[`ECC_POS_W-1:0];
                cols[n] = {($countones(pos) % 2) == 0, pos};
                n++;
            end
        end
    endtask

    function automatic ecc_parity_t encode_data(input ecc_data_t d);
        ecc_parity_t par;
        par = '0;
        for (int i = 0; i < `ECC_DATA_W; i++) begin
            if (d[i]) begin
                par = par ^ cols[i];
            end
        end
        return par;
    endfunction

    function automatic ecc_data_t rand_data();
        logic [95:0] r;
        r = {$urandom(), $urandom(), $urandom()};
        return r[`ECC_DATA_W-1:0];
    endfunction

    function automatic ecc_data_t flip_bit(input int b);
        return ecc_data_t'(1) << b;
    endfunction

    function automatic string kind_name(input logic [2:0] kind);
        case (kind)
            k_clean: return "clean";
            k_sdata: return "single data";
            k_scheck: return "single check";
            k_double: return "double";
            k_bypass: return "bypass";
            default: return "credit";
        endcase
    endfunction

    task automatic add_vec(input logic [2:0] kind, input ecc_data_t df, input ecc_parity_t pf,
                           input logic byp, input logic sb, input logic db);
        vec_t v;
        v.kind = kind;
        v.data = rand_data();
        v.dflip = df;
        v.pflip = pf;
        v.bypass = byp;
        v.exp_sbit = sb;
        v.exp_dbit = db;
        vecs[fill_idx] = v;
        fill_idx++;
    endtask

    task automatic fill_table();
        int p1;
        int p2;
        fill_idx = 0;
        for (int k = 0; k < 3; k++) begin
            add_vec(k_clean, '0, '0, 1'b0, 1'b0, 1'b0);
        end
        vecs[1].data = '0;
        vecs[2].data = '1;
        add_vec(k_sdata, flip_bit(0), '0, 1'b0, 1'b1, 1'b0);
        add_vec(k_sdata, flip_bit(3), '0, 1'b0, 1'b1, 1'b0);
        add_vec(k_sdata, flip_bit(83), '0, 1'b0, 1'b1, 1'b0);
        for (int k = 0; k < 3; k++) begin
            p1 = int'($urandom_range(`ECC_DATA_W - 1, 0));
            add_vec(k_sdata, flip_bit(p1), '0, 1'b0, 1'b1, 1'b0);
        end
        for (int j = 0; j < `ECC_PARITY_W; j++) begin
            add_vec(k_scheck, '0, ecc_parity_t'(1) << j, 1'b0, 1'b1, 1'b0);
        end
        for (int k = 0; k < 2; k++) begin
            p1 = int'($urandom_range(`ECC_DATA_W - 1, 0));
            p2 = (p1 + 1 + int'($urandom_range(`ECC_DATA_W - 2, 0))) % `ECC_DATA_W;
            add_vec(k_double, flip_bit(p1) | flip_bit(p2), '0, 1'b0, 1'b0, 1'b1);
        end
        add_vec(k_double, flip_bit(p1), 8'h10, 1'b0, 1'b0, 1'b1);   // data plus check bit
        add_vec(k_bypass, flip_bit(p2), '0, 1'b1, 1'b0, 1'b0);
        add_vec(k_bypass, flip_bit(p1) | flip_bit(p2), '0, 1'b1, 1'b0, 1'b0);
        for (int k = 0; k < n_bp; k++) begin
            add_vec(k_credit, '0, '0, 1'b0, 1'b0, 1'b0);
        end
    endtask

    // called at rising edge plus 2 ns, leaves the word on the bus
    task automatic send_word(input int idx);
        @(posedge clk);
        #2;
        in_valid = 1'b0;
        while (`ECC_IN_DEPTH + returned - sent == 0) begin
            @(posedge clk);
            #2;
        end
        in_word.data = vecs[idx].data ^ vecs[idx].dflip;
        in_word.parity = encode_data(vecs[idx].data) ^ vecs[idx].pflip;
        in_word.bypass = vecs[idx].bypass;
        in_valid = 1'b1;
        sent++;
        exp_q.push_back(idx);
    endtask

    task automatic release_input();
        @(posedge clk);
        #2;
        in_valid = 1'b0;
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0 || owed != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic check_output();
        vec_t v;
        ecc_data_t rx;
        ecc_data_t exp_data;
        ecc_parity_t exp_par;
        int idx;
        int errs;
        errs = 0;
        if (exp_q.size() == 0) begin
            $display("out_valid was asserted with no word outstanding");
            error_count++;
            return;
        end
        idx = exp_q.pop_front();
        v = vecs[idx];
        rx = v.data ^ v.dflip;
        exp_par = encode_data(rx);
        exp_data = rx;
        if (!v.bypass && v.exp_sbit && v.dflip != '0) begin
            exp_data = v.data;                  // corrected back to the clean word
        end
        if (out_word.data !== exp_data) begin
            $display("error: test %0d out_word.data got %h expected %h", idx, out_word.data,
                     exp_data);
            errs++;
        end
        if (out_word.calc_parity !== exp_par) begin
            $display("error: test %0d out_word.calc_parity got %h expected %h", idx,
                     out_word.calc_parity, exp_par);
            errs++;
        end
        if (out_word.sbit_err !== v.exp_sbit) begin
            $display("error: test %0d out_word.sbit_err got %h expected %h", idx,
                     out_word.sbit_err, v.exp_sbit);
            errs++;
        end
        if (out_word.dbit_err !== v.exp_dbit) begin
            $display("error: test %0d out_word.dbit_err got %h expected %h", idx,
                     out_word.dbit_err, v.exp_dbit);
            errs++;
        end
        recv_count++;
        test_count++;
        if (errs == 0) begin
            $display("test %0d %s: ok", idx, kind_name(v.kind));
        end else begin
            $display("test %0d %s: %0d mismatches", idx, kind_name(v.kind), errs);
            fail_count++;
            error_count += errs;
        end
    endtask

    always @(negedge clk) begin
        if (!reset) begin
            if (in_credit) begin
                returned++;
            end
            if (out_valid) begin
                owed++;
                check_output();
            end
        end
    end

    // downstream frees one slot per cycle unless held
    always @(posedge clk) begin
        #2;
        if (!hold && owed > 0) begin
            out_credit = 1'b1;
            owed--;
        end else begin
            out_credit = 1'b0;
        end
    end

    initial begin
        #(watchdog_ns);
        $display("watchdog: run did not finish within %0d ns", watchdog_ns);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        int start;
        void'($urandom(32'h28a1_1bbd));
        reset = 1'b1;
        in_valid = 1'b0;
        in_word = '0;
        out_credit = 1'b0;
        hold = 1'b0;
        sent = 0;
        returned = 0;
        owed = 0;
        recv_count = 0;
        test_count = 0;
        fail_count = 0;
        error_count = 0;
        build_columns();
        fill_table();
        repeat (8) @(posedge clk);
        #2;
        reset = 1'b0;
        for (int i = 0; i < n_main; i++) begin
            send_word(i);
        end
        release_input();
        wait_drained();
        @(negedge clk);
        hold = 1'b1;
        start = recv_count;
        for (int i = n_main; i < n_vecs; i++) begin
            send_word(i);
        end
        release_input();
        repeat (12) @(negedge clk);
        test_count++;
        if (recv_count - start != `ECC_OUT_CREDITS) begin
            $display("back-pressure: %0d words came out with credits withheld, expected %0d",
                     recv_count - start, `ECC_OUT_CREDITS);
            fail_count++;
            error_count++;
        end else begin
            $display("back-pressure: ok");
        end
        hold = 1'b0;
        wait_drained();
        test_count++;
        if (returned != sent) begin
            $display("input credits: %0d returned for %0d words sent", returned, sent);
            fail_count++;
            error_count++;
        end else begin
            $display("input credits: ok");
        end
        $display("%0d tests run, %0d failed, %0d errors", test_count, fail_count, error_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+verilog
verilog/ecc_pkg.sv
verilog/ecc_issue.sv
verilog/ecc_syndrome_stage.sv
verilog/ecc_correct_stage.sv
verilog/ecc_pipe_top.sv
dv/ecc_pipe_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile with verilator, run, then scan the simulation log
cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 -f vlog.f --top-module ecc_pipe_tb -o ecc_pipe_sim > build.log 2>&1 \
    && ./obj_dir/ecc_pipe_sim > sim.log 2>&1 \
    || { echo "build or simulation failed, see build.log and sim.log"; exit 1; }

if grep -q "FAIL: see errors above" sim.log; then
    echo "simulation reported failures, see sim.log"
    exit 1
fi
echo "simulation passed"
